// ==== Bender.yml ====
package:
  name: dcache

sources:
  - src/dcache_pkg.sv
  - src/dcache_beat_cnt.sv
  - src/dcache_tag_array.sv
  - src/dcache_data_array.sv
  - src/dcache_ctrl.sv
  - src/dcache_top.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_dcache.sv

// ==== dv/tb_clk_gen.sv ====
// ----------------------------------------------------------
// testbench clock source, free running
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// ==== dv/tb_dcache.sv ====
// ----------------------------------------------------------
// dcache testbench
// random cpu traffic with a memory responder and a shadow
// model of the cache state and contents
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_dcache import dcache_pkg::*; ();

    localparam int INDEX_W       = 6;     // dut default
    localparam int CLK_PERIOD_NS = 4;
    localparam int RESET_CYCLES  = 8;
    localparam int N_REQ         = 2000;
    localparam int N_CONFLICT    = 300;   // tail of the run stays in set 0
    localparam int MAX_DELAY     = 3;
    localparam int SEED          = 85;
    localparam int N_SETS        = 4;     // sets the traffic touches
    localparam int N_TAGS        = 4;
    localparam int TAG_SHIFT     = INDEX_W + LINE_OFF_W;
    // lookup, writeback, refill request, four beats, final lookup, idle gap
    localparam int WORST_MISS_CYCLES = 4 + (2 + LINE_WORDS) * (MAX_DELAY + 1);
    localparam longint TIMEOUT_NS =
        longint'(RESET_CYCLES + 8 + N_REQ * WORST_MISS_CYCLES) * CLK_PERIOD_NS;

    logic  clk;
    logic  rst_n;
    logic  cpu_req;
    logic  cpu_we;
    addr_t cpu_addr;
    strb_t cpu_wstrb;
    word_t cpu_wdata;
    logic  ack;
    word_t rdata;
    logic  mem_wr_req;
    addr_t mem_wr_addr;
    line_t mem_wr_line;
    logic  mem_wr_rdy;
    logic  mem_rd_req;
    addr_t mem_rd_addr;
    logic  mem_rd_rdy;
    logic  mem_rd_valid;
    word_t mem_rd_data;

    // ----------------------------------------------------------
    // reference model
    // ----------------------------------------------------------
    word_t shadow_mem  [N_SETS*N_TAGS][LINE_WORDS];  // what the cpu must see
    word_t backing_mem [N_SETS*N_TAGS][LINE_WORDS];  // what memory holds
    logic  m_valid [N_SETS][2];
    logic  m_dirty [N_SETS][2];
    int    m_tag   [N_SETS][2];
    logic  m_lru   [N_SETS];

    logic  exp_hit;
    logic  exp_wb;
    word_t exp_rdata;
    addr_t exp_wb_addr;
    addr_t exp_rd_addr;
    line_t exp_wb_line;
    int    vic_lid;

    int          err_cnt;
    int          check_cnt;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clk_gen (.clk_o(clk));

    dcache_top dcache_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .cpu_req_i      (cpu_req),
        .cpu_we_i       (cpu_we),
        .cpu_addr_i     (cpu_addr),
        .cpu_wstrb_i    (cpu_wstrb),
        .cpu_wdata_i    (cpu_wdata),
        .ack_o          (ack),
        .rdata_o        (rdata),
        .mem_wr_req_o   (mem_wr_req),
        .mem_wr_addr_o  (mem_wr_addr),
        .mem_wr_line_o  (mem_wr_line),
        .mem_wr_rdy_i   (mem_wr_rdy),
        .mem_rd_req_o   (mem_rd_req),
        .mem_rd_addr_o  (mem_rd_addr),
        .mem_rd_rdy_i   (mem_rd_rdy),
        .mem_rd_valid_i (mem_rd_valid),
        .mem_rd_data_i  (mem_rd_data)
    );

    function automatic int line_id(input int tag, input int set);
        return tag * N_SETS + set;
    endfunction

    function automatic addr_t line_addr(input int tag, input int set);
        return (addr_t'(tag) << TAG_SHIFT) | (addr_t'(set) << LINE_OFF_W);
    endfunction

    // rotate and mix so every address bit shows up
    function automatic word_t fill_word(input addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5A3C_96E1;
    endfunction

    function automatic int rand_below(input int n);
        return int'($urandom % n);
    endfunction

    function automatic line_t pack_line(input int lid);
        line_t l;
        for (int w = 0; w < LINE_WORDS; w++) begin
            l[w*WORD_W +: WORD_W] = shadow_mem[lid][w];
        end
        return l;
    endfunction

    // ----------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------
    task automatic log_error(input string msg);
        err_cnt++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_quiet_outputs();
        check_flag("ack_o", ack, 1'b0);
        check_flag("mem_wr_req_o", mem_wr_req, 1'b0);
        check_flag("mem_rd_req_o", mem_rd_req, 1'b0);
    endtask

    task automatic init_model();
        for (int lid = 0; lid < N_SETS * N_TAGS; lid++) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                backing_mem[lid][w] = fill_word(line_addr(lid / N_SETS, lid % N_SETS)
                                                + addr_t'(w << BYTE_OFF_W));
                shadow_mem[lid][w]  = backing_mem[lid][w];
            end
        end
        for (int s = 0; s < N_SETS; s++) begin
            m_valid[s] = '{1'b0, 1'b0};
            m_dirty[s] = '{1'b0, 1'b0};
            m_tag[s]   = '{0, 0};
            m_lru[s]   = 1'b0;
        end
    endtask

    // predicts the outcome of one request and moves the model past it
    task automatic model_request(input logic we, input int tag, input int set,
                                 input int word, input strb_t strb, input word_t wdata);
        int lid;
        int way;
        int vic;
        lid       = line_id(tag, set);
        exp_hit   = 1'b0;
        exp_wb    = 1'b0;
        way       = 0;
        exp_rdata = shadow_mem[lid][word];
        exp_rd_addr = line_addr(tag, set);
        for (int w = 0; w < 2; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == tag) begin
                exp_hit = 1'b1;
                way     = w;
            end
        end
        if (!exp_hit) begin
            if (!m_valid[set][0]) vic = 0;         // empty way first
            else if (!m_valid[set][1]) vic = 1;
            else vic = int'(m_lru[set]);
            if (m_valid[set][vic] && m_dirty[set][vic]) begin
                exp_wb      = 1'b1;
                vic_lid     = line_id(m_tag[set][vic], set);
                exp_wb_addr = line_addr(m_tag[set][vic], set);
                exp_wb_line = pack_line(vic_lid);
            end
            m_valid[set][vic] = 1'b1;
            m_dirty[set][vic] = 1'b0;
            m_tag[set][vic]   = tag;
            way               = vic;
        end
        m_lru[set] = (way == 0);  // the other way becomes lru
        if (we) begin
            m_dirty[set][way] = 1'b1;
            for (int b = 0; b < STRB_W; b++) begin
                if (strb[b]) shadow_mem[lid][word][8*b +: 8] = wdata[8*b +: 8];
            end
        end
    endtask

    // ----------------------------------------------------------
    // one cpu request with the memory responder
    // ----------------------------------------------------------
    task automatic run_request(input logic we, input int tag, input int set,
                               input int word, input strb_t strb, input word_t wdata);
        int   lat;
        int   wb_cnt;
        int   rd_cnt;
        int   beat;
        int   gap;
        int   wr_wait;
        int   rd_wait;
        int   rd_lid;
        logic refilling;
        logic done;
        model_request(we, tag, set, word, strb, wdata);
        rd_lid    = line_id(tag, set);
        wr_wait   = rand_below(MAX_DELAY + 1);
        rd_wait   = rand_below(MAX_DELAY + 1);
        lat       = 0;
        wb_cnt    = 0;
        rd_cnt    = 0;
        beat      = 0;
        gap       = 0;
        refilling = 1'b0;
        done      = 1'b0;
        @(negedge clk);
        cpu_req   = 1'b1;
        cpu_we    = we;
        cpu_addr  = line_addr(tag, set) | addr_t'(word << BYTE_OFF_W);
        cpu_wstrb = strb;
        cpu_wdata = wdata;
        while (!done) begin
            @(negedge clk);
            lat++;
            mem_wr_rdy   = 1'b0;   // handshakes last one cycle
            mem_rd_rdy   = 1'b0;
            mem_rd_valid = 1'b0;
            if (ack) begin
                done = 1'b1;
                if (!we) check_word("rdata_o", rdata, exp_rdata);
                if (exp_hit && (lat != 1 || wb_cnt != 0 || rd_cnt != 0)) begin
                    log_error($sformatf("hit at 0x%h took %0d cycles, %0d writebacks, %0d refills",
                                        cpu_addr, lat, wb_cnt, rd_cnt));
                end
                if (!exp_hit && (rd_cnt != 1 || beat != LINE_WORDS)) begin
                    log_error($sformatf("miss at 0x%h acknowledged without one full refill",
                                        cpu_addr));
                end
                if (wb_cnt != int'(exp_wb)) begin
                    log_error($sformatf("miss at 0x%h gave %0d writebacks, expected %0d",
                                        cpu_addr, wb_cnt, int'(exp_wb)));
                end
            end else begin
                if (refilling && beat < LINE_WORDS) begin
                    if (gap == 0) begin
                        mem_rd_valid = 1'b1;
                        mem_rd_data  = backing_mem[rd_lid][beat];
                        beat++;
                        gap = rand_below(MAX_DELAY + 1);
                    end else begin
                        gap--;
                    end
                end
                if (mem_wr_req) begin
                    if (wr_wait == 0) begin
                        mem_wr_rdy = 1'b1;
                        wb_cnt++;
                        if (!exp_wb) begin
                            log_error("writeback issued for a clean or empty victim");
                        end else begin
                            check_addr("mem_wr_addr_o", mem_wr_addr, exp_wb_addr);
                            check_line("mem_wr_line_o", mem_wr_line, exp_wb_line);
                            for (int w = 0; w < LINE_WORDS; w++) begin
                                backing_mem[vic_lid][w] = mem_wr_line[w*WORD_W +: WORD_W];
                            end
                        end
                    end else begin
                        wr_wait--;
                    end
                end
                if (mem_rd_req) begin
                    if (rd_wait == 0) begin
                        mem_rd_rdy = 1'b1;
                        rd_cnt++;
                        check_addr("mem_rd_addr_o", mem_rd_addr, exp_rd_addr);
                        refilling = 1'b1;   // beats start next cycle
                        beat      = 0;
                        gap       = rand_below(MAX_DELAY + 1);
                    end else begin
                        rd_wait--;
                    end
                end
            end
        end
    endtask

    task automatic run_traffic();
        logic  we;
        int    set;
        int    tag;
        int    word;
        strb_t strb;
        word_t wdata;
        for (int i = 0; i < N_REQ; i++) begin
            if (i >= N_REQ - N_CONFLICT) begin
                set = 0;
                tag = rand_below(3);   // three tags fight over two ways
            end else begin
                set = rand_below(N_SETS);
                tag = rand_below(N_TAGS);
            end
            we    = logic'(rand_below(2));
            word  = rand_below(LINE_WORDS);
            strb  = strb_t'(rand_below(16));
            wdata = word_t'($urandom);
            run_request(we, tag, set, word, strb, wdata);
            if (rand_below(4) == 0) begin
                @(negedge clk);
                cpu_req = 1'b0;
            end
        end
        @(negedge clk);
        cpu_req = 1'b0;
    endtask

    // ----------------------------------------------------------
    // main sequence and watchdog
    // ----------------------------------------------------------
    initial begin
        void'($urandom(SEED));
        err_cnt      = 0;
        check_cnt    = 0;
        rst_n        = 1'b0;
        cpu_req      = 1'b0;
        cpu_we       = 1'b0;
        cpu_addr     = '0;
        cpu_wstrb    = '0;
        cpu_wdata    = '0;
        mem_wr_rdy   = 1'b0;
        mem_rd_rdy   = 1'b0;
        mem_rd_valid = 1'b0;
        mem_rd_data  = '0;
        init_model();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_quiet_outputs();
        end
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_quiet_outputs();   // nothing moves before the first request
        end
        run_traffic();
        @(negedge clk);
        $display("checks run: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/dcache_pkg.sv
src/dcache_beat_cnt.sv
src/dcache_tag_array.sv
src/dcache_data_array.sv
src/dcache_ctrl.sv
src/dcache_top.sv
dv/tb_clk_gen.sv
dv/tb_dcache.sv

// ==== src/dcache_beat_cnt.sv ====
// ----------------------------------------------------------
// dcache refill beat counter
// word position of the next beat and last-beat flag
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_beat_cnt import dcache_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,
    input  wire       clr_i,
    input  wire       en_i,
    output word_sel_t beat_o,
    output logic      last_o
);

    localparam word_sel_t LAST_BEAT = word_sel_t'(LINE_WORDS - 1);

    word_sel_t cnt_q;
    logic      done_q;  // full line seen since clear

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q  <= '0;
            done_q <= 1'b0;
        end else if (clr_i) begin
            cnt_q  <= '0;
            done_q <= 1'b0;
        end else if (en_i) begin
            cnt_q  <= cnt_q + 1'b1;   // wraps after the last word
            done_q <= done_q | last_o;
        end
    end

    assign beat_o = cnt_q;
    assign last_o = en_i && (cnt_q == LAST_BEAT);

    a_no_extra_beat: assert property (@(posedge clk) disable iff (!rst_n)
        !(done_q && en_i && !clr_i));

endmodule

`default_nettype wire

// ==== src/dcache_ctrl.sv ====
// ----------------------------------------------------------
// dcache controller
// request capture and hit / miss / writeback / refill FSM
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; #(
    parameter int INDEX_W = 6,
    parameter int TAG_W   = ADDR_W - INDEX_W - LINE_OFF_W
) (
    input  wire                clk,
    input  wire                rst_n,
    // cpu side
    input  wire                cpu_req_i,
    input  wire                cpu_we_i,
    input  wire addr_t         cpu_addr_i,
    input  wire strb_t         cpu_wstrb_i,
    input  wire word_t         cpu_wdata_i,
    output logic               ack_o,
    // tag array status
    input  wire                hit_i,
    input  wire                victim_dirty_i,
    input  wire [TAG_W-1:0]    victim_tag_i,
    // array control
    output logic [INDEX_W-1:0] index_o,
    output logic [TAG_W-1:0]   tag_o,
    output word_sel_t          word_sel_o,
    output logic               we_o,
    output strb_t              wstrb_o,
    output word_t              wdata_o,
    output logic               hit_wr_o,
    output logic               lru_upd_o,
    output logic               refill_fill_o,
    output logic               install_o,
    // beat counter
    output logic               cnt_clr_o,
    input  wire                beat_last_i,
    // memory side
    output logic               mem_wr_req_o,
    output addr_t              mem_wr_addr_o,
    input  wire                mem_wr_rdy_i,
    output logic               mem_rd_req_o,
    output addr_t              mem_rd_addr_o,
    input  wire                mem_rd_rdy_i,
    input  wire                mem_rd_valid_i
);

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    logic   req_we_q;
    addr_t  req_addr_q;
    strb_t  req_strb_q;
    word_t  req_wdata_q;
    index_t req_index;
    tag_t   req_tag;

    assign req_index = req_addr_q[LINE_OFF_W +: INDEX_W];
    assign req_tag   = req_addr_q[ADDR_W-1 -: TAG_W];

    // ----------------------------------------------------------
    // state machine
    // ----------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (cpu_req_i) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit_i) begin
                    state_d = ST_IDLE;
                end else if (victim_dirty_i) begin
                    state_d = ST_WRITEBACK;
                end else begin
                    state_d = ST_REFILL_REQ;
                end
            end
            ST_WRITEBACK: begin
                if (mem_wr_rdy_i) begin
                    state_d = ST_REFILL_REQ;
                end
            end
            ST_REFILL_REQ: begin
                if (mem_rd_rdy_i) begin
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (install_o) begin
                    state_d = ST_LOOKUP;  // replay, now hits
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request capture
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && cpu_req_i) begin
            req_we_q    <= cpu_we_i;
            req_addr_q  <= cpu_addr_i;
            req_strb_q  <= cpu_wstrb_i;
            req_wdata_q <= cpu_wdata_i;
        end
    end

    // ----------------------------------------------------------
    // outputs
    // ----------------------------------------------------------
    assign ack_o      = (state_q == ST_LOOKUP) && hit_i;
    assign lru_upd_o  = ack_o;
    assign hit_wr_o   = ack_o && req_we_q;  // also merges a write miss after refill
    assign we_o       = hit_wr_o;
    assign index_o    = req_index;
    assign tag_o      = req_tag;
    assign word_sel_o = req_addr_q[BYTE_OFF_W +: WORD_SEL_W];
    assign wstrb_o    = req_strb_q;
    assign wdata_o    = req_wdata_q;

    assign refill_fill_o = (state_q == ST_REFILL) && mem_rd_valid_i;
    assign install_o     = refill_fill_o && beat_last_i;
    assign cnt_clr_o     = (state_q == ST_REFILL_REQ);

    assign mem_wr_req_o  = (state_q == ST_WRITEBACK);
    assign mem_wr_addr_o = {victim_tag_i, req_index, {LINE_OFF_W{1'b0}}};
    assign mem_rd_req_o  = (state_q == ST_REFILL_REQ);
    assign mem_rd_addr_o = {req_tag, req_index, {LINE_OFF_W{1'b0}}};

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------
    a_beat_in_refill: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rd_valid_i |-> state_q == ST_REFILL);

    // cpu must hold what was captured until the ack
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        state_q != ST_IDLE |-> cpu_req_i && cpu_we_i == req_we_q
            && cpu_addr_i == req_addr_q && cpu_wstrb_i == req_strb_q
            && cpu_wdata_i == req_wdata_q);

endmodule

`default_nettype wire

// ==== src/dcache_data_array.sv ====
// ----------------------------------------------------------
// dcache data array
// two-way line storage, word read and strobed write, refill
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array import dcache_pkg::*; #(
    parameter int INDEX_W = 6
) (
    input  wire               clk,
    input  wire [INDEX_W-1:0] index_i,
    input  wire word_sel_t    word_sel_i,
    input  wire               hit_way_i,
    input  wire               victim_way_i,
    input  wire               wr_i,
    input  wire strb_t        wstrb_i,
    input  wire word_t        wdata_i,
    input  wire               fill_i,
    input  wire word_sel_t    fill_sel_i,
    input  wire word_t        fill_data_i,
    output word_t             rdata_o,
    output line_t             victim_line_o
);

    localparam int SETS = 2 ** INDEX_W;

    typedef logic [INDEX_W-1:0] index_t;

    word_t  word_mem [2][SETS][LINE_WORDS];
    index_t idx;

    assign idx     = index_i;
    assign rdata_o = word_mem[hit_way_i][idx][word_sel_i];

    // word 0 in the low bits of the line
    always_comb begin
        for (int w = 0; w < LINE_WORDS; w++) begin
            victim_line_o[w*WORD_W +: WORD_W] = word_mem[victim_way_i][idx][w];
        end
    end

    // ----------------------------------------------------------
    // write port
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (fill_i) begin
            word_mem[victim_way_i][idx][fill_sel_i] <= fill_data_i;
        end else if (wr_i) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wstrb_i[b]) begin
                    word_mem[hit_way_i][idx][word_sel_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/dcache_pkg.sv ====
// ----------------------------------------------------------
// dcache shared definitions
// geometry constants, vector types and controller states
// ----------------------------------------------------------
`default_nettype none

package dcache_pkg;

    // ----------------------------------------------------------
    // geometry
    // ----------------------------------------------------------
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int WORD_SEL_W = 2;                        // log2 of LINE_WORDS
    localparam int ADDR_W     = 32;
    localparam int STRB_W     = WORD_W / 8;               // one enable per byte
    localparam int BYTE_OFF_W = 2;
    localparam int LINE_OFF_W = WORD_SEL_W + BYTE_OFF_W;  // byte offset in a line
    localparam int LINE_W     = WORD_W * LINE_WORDS;

    // ----------------------------------------------------------
    // vector types
    // ----------------------------------------------------------
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [STRB_W-1:0]     strb_t;
    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;

    // controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,     // dirty victim out to memory
        ST_REFILL_REQ,
        ST_REFILL         // four beats in
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== src/dcache_tag_array.sv ====
// ----------------------------------------------------------
// dcache tag array
// tag, valid, dirty and lru per set, hit and victim choice
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array import dcache_pkg::*; #(
    parameter int INDEX_W = 6,
    parameter int TAG_W   = ADDR_W - INDEX_W - LINE_OFF_W
) (
    input  wire               clk,
    input  wire               rst_n,
    input  wire [INDEX_W-1:0] index_i,
    input  wire [TAG_W-1:0]   tag_i,
    input  wire               hit_wr_i,
    input  wire               lru_upd_i,
    input  wire               install_i,
    output logic              hit_o,
    output logic              hit_way_o,
    output logic              victim_way_o,
    output logic              victim_dirty_o,
    output logic [TAG_W-1:0]  victim_tag_o
);

    localparam int SETS = 2 ** INDEX_W;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    tag_t                 tag_mem [2][SETS];
    logic [SETS-1:0][1:0] valid_q;
    logic [SETS-1:0][1:0] dirty_q;
    logic [SETS-1:0]      lru_q;   // least recently used way

    index_t     idx;
    logic [1:0] way_valid;
    logic [1:0] way_dirty;
    logic [1:0] way_hit;

    assign idx       = index_i;
    assign way_valid = valid_q[idx];
    assign way_dirty = dirty_q[idx];

    // ----------------------------------------------------------
    // lookup
    // ----------------------------------------------------------
    assign way_hit[0] = way_valid[0] && (tag_mem[0][idx] == tag_i);
    assign way_hit[1] = way_valid[1] && (tag_mem[1][idx] == tag_i);
    assign hit_o      = |way_hit;
    assign hit_way_o  = way_hit[1];

    // empty way first, way 0 before way 1
    always_comb begin
        if (!way_valid[0]) begin
            victim_way_o = 1'b0;
        end else if (!way_valid[1]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = lru_q[idx];
        end
    end

    assign victim_dirty_o = way_valid[victim_way_o] && way_dirty[victim_way_o];
    assign victim_tag_o   = tag_mem[victim_way_o][idx];

    // ----------------------------------------------------------
    // update
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (install_i) begin
            tag_mem[victim_way_o][idx] <= tag_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (install_i) begin
                valid_q[idx][victim_way_o] <= 1'b1;
                dirty_q[idx][victim_way_o] <= 1'b0;  // fresh line from memory
                lru_q[idx]                 <= ~victim_way_o;
            end
            if (hit_wr_i) begin
                dirty_q[idx][hit_way_o] <= 1'b1;
            end
            if (lru_upd_i) begin
                lru_q[idx] <= ~hit_way_o;
            end
        end
    end

    a_one_way_hit: assert property (@(posedge clk) disable iff (!rst_n)
        !(way_hit[0] && way_hit[1]));

endmodule

`default_nettype wire

// ==== src/dcache_top.sv ====
// ----------------------------------------------------------
// dcache top
// two-way write-back cache, controller plus arrays
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; #(
    parameter int INDEX_W = 6,
    parameter int TAG_W   = ADDR_W - INDEX_W - LINE_OFF_W
) (
    input  wire   clk,
    input  wire   rst_n,
    // cpu port
    input  wire   cpu_req_i,
    input  wire   cpu_we_i,
    input  wire addr_t cpu_addr_i,
    input  wire strb_t cpu_wstrb_i,
    input  wire word_t cpu_wdata_i,
    output logic  ack_o,
    output word_t rdata_o,
    // memory port
    output logic  mem_wr_req_o,
    output addr_t mem_wr_addr_o,
    output line_t mem_wr_line_o,
    input  wire   mem_wr_rdy_i,
    output logic  mem_rd_req_o,
    output addr_t mem_rd_addr_o,
    input  wire   mem_rd_rdy_i,
    input  wire   mem_rd_valid_i,
    input  wire word_t mem_rd_data_i
);

    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;
    word_sel_t          word_sel;
    logic               we;
    strb_t              wstrb;
    word_t              wdata;
    logic               hit_wr;
    logic               lru_upd;
    logic               refill_fill;
    logic               install;
    logic               cnt_clr;
    logic               hit;
    logic               hit_way;
    logic               victim_way;
    logic               victim_dirty;
    logic [TAG_W-1:0]   victim_tag;
    word_sel_t          beat;
    logic               beat_last;

    dcache_ctrl #(.INDEX_W(INDEX_W), .TAG_W(TAG_W)) u_ctrl (
        .clk, .rst_n,
        .cpu_req_i, .cpu_we_i, .cpu_addr_i, .cpu_wstrb_i, .cpu_wdata_i, .ack_o,
        .hit_i          (hit),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .index_o        (index),
        .tag_o          (tag),
        .word_sel_o     (word_sel),
        .we_o           (we),
        .wstrb_o        (wstrb),
        .wdata_o        (wdata),
        .hit_wr_o       (hit_wr),
        .lru_upd_o      (lru_upd),
        .refill_fill_o  (refill_fill),
        .install_o      (install),
        .cnt_clr_o      (cnt_clr),
        .beat_last_i    (beat_last),
        .mem_wr_req_o, .mem_wr_addr_o, .mem_wr_rdy_i,
        .mem_rd_req_o, .mem_rd_addr_o, .mem_rd_rdy_i, .mem_rd_valid_i
    );

    dcache_beat_cnt u_beat_cnt (
        .clk, .rst_n,
        .clr_i  (cnt_clr),
        .en_i   (refill_fill),
        .beat_o (beat),
        .last_o (beat_last)
    );

    dcache_tag_array #(.INDEX_W(INDEX_W), .TAG_W(TAG_W)) u_tag_array (
        .clk, .rst_n,
        .index_i        (index),
        .tag_i          (tag),
        .hit_wr_i       (hit_wr),
        .lru_upd_i      (lru_upd),
        .install_i      (install),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    dcache_data_array #(.INDEX_W(INDEX_W)) u_data_array (
        .clk,
        .index_i       (index),
        .word_sel_i    (word_sel),
        .hit_way_i     (hit_way),
        .victim_way_i  (victim_way),
        .wr_i          (we),
        .wstrb_i       (wstrb),
        .wdata_i       (wdata),
        .fill_i        (refill_fill),
        .fill_sel_i    (beat),
        .fill_data_i   (mem_rd_data_i),
        .rdata_o       (rdata_o),
        .victim_line_o (mem_wr_line_o)
    );

endmodule

`default_nettype wire
